//--- verilog/bp_params.svh
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// history length, also the counter table index width
`define BP_GH_WIDTH 12

// jumps in flight, sets checkpoint and tracker depth
`define BP_QUEUE_LEN 16

// fetch address width
`define BP_PC_WIDTH 32

// lowest pc bit in the index, instructions are word aligned
`define BP_PC_LSB 2

`endif

//--- verilog/bp_fetch_pkg.sv
`include "bp_params.svh"

package bp_fetch_pkg;

    // table index, same width as the history
    typedef logic [`BP_GH_WIDTH-1:0] index_t;

    typedef logic [`BP_PC_WIDTH-1:0] pc_t;

    // request from the fetch stage, 34 bits
    typedef struct packed {
        logic   valid;
        logic   is_jump;
        pc_t    pc;
    } fetch_req_t;

    // prediction handed back one cycle later, 15 bits
    typedef struct packed {
        logic   valid;
        logic   is_jump;
        logic   taken;     // upper counter bit
        index_t index;     // pc bits xor history
    } pred_t;

endpackage

//--- verilog/bp_resolve_pkg.sv
`include "bp_params.svh"

package bp_resolve_pkg;

    // execute stage outcome, always for the oldest jump
    typedef struct packed {
        logic valid;
        logic taken;
    } resolve_t;

    // counter table write, 14 bits
    typedef struct packed {
        logic                 valid;
        bp_fetch_pkg::index_t index;
        logic                 taken;   // real outcome
    } pht_upd_t;

    // mispredict report, 13 bits
    typedef struct packed {
        logic                 valid;
        bp_fetch_pkg::index_t index;   // entry that was wrong
    } mispredict_t;

endpackage

//--- verilog/fetch_capture.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module fetch_capture (
    input  logic                      clk,
    input  logic                      rstn,
    input  bp_fetch_pkg::fetch_req_t  fetch,
    input  logic [`BP_GH_WIDTH-1:0]   gh,
    input  logic                      flush,
    output bp_fetch_pkg::pred_t       pred_req,
    output logic [`BP_GH_WIDTH-1:0]   index
);

    logic                     valid_q;
    logic                     is_jump_q;
    logic [`BP_PC_WIDTH-1:0]  pc_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch.valid && !flush;   // squashed on mispredict
        end
    end

    always_ff @(posedge clk) begin
        is_jump_q <= fetch.is_jump;
        pc_q      <= fetch.pc;
    end

    // gshare hash against the live history
    assign index = pc_q[`BP_PC_LSB +: `BP_GH_WIDTH] ^ gh;

    always_comb begin
        pred_req.valid   = valid_q;
        pred_req.is_jump = is_jump_q;
        pred_req.taken   = 1'b0;        // filled in from the table
        pred_req.index   = index;
    end

endmodule

//--- verilog/ghr.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module ghr (
    input  logic                     clk,
    input  logic                     rstn,
    output logic [`BP_GH_WIDTH-1:0]  gh,
    input  logic                     taken_pdc,
    input  logic                     mis_pdc,
    input  logic                     is_jump_pdc,
    input  logic                     is_jump_ex,
    input  logic                     update_en
);

    localparam int GH_W   = `BP_GH_WIDTH;
    localparam int DEPTH  = `BP_QUEUE_LEN;
    localparam int SLOT_W = $clog2(DEPTH);
    localparam int PTR_W  = $clog2(DEPTH + 1);

    // corrected histories, newest at entry 0
    logic [GH_W-1:0]   chkpt_q [0:DEPTH-1];
    logic [PTR_W-1:0]  pointer;     // outstanding jumps
    logic [PTR_W-1:0]  oldest;
    logic              push;

    assign push   = update_en && is_jump_pdc && !mis_pdc;
    assign oldest = pointer - 1'b1;

    // history as it would be had the guess been wrong
    always_ff @(posedge clk) begin
        if (push) begin
            chkpt_q[0] <= {gh[GH_W-2:0], ~taken_pdc};
            for (int i = 1; i < DEPTH; i++) begin
                chkpt_q[i] <= chkpt_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pointer <= '0;
        end else if (update_en) begin
            if (mis_pdc) begin
                pointer <= '0;                  // younger jumps squashed
            end else if (is_jump_ex && !is_jump_pdc) begin
                pointer <= pointer - 1'b1;
            end else if (is_jump_pdc && !is_jump_ex) begin
                pointer <= pointer + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            gh <= '0;
        end else if (update_en) begin
            if (mis_pdc) begin
                gh <= chkpt_q[oldest[SLOT_W-1:0]];  // restore oldest checkpoint
            end else if (is_jump_pdc) begin
                gh <= {gh[GH_W-2:0], taken_pdc};
            end
        end
    end

endmodule

//--- verilog/pht.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module pht (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [`BP_GH_WIDTH-1:0]   rd_index,
    output logic                      taken,
    input  bp_resolve_pkg::pht_upd_t  upd
);

    localparam int IDX_W = `BP_GH_WIDTH;
    localparam int DEPTH = 1 << IDX_W;

    logic [1:0]        cnt_mem [0:DEPTH-1];
    logic [IDX_W-1:0]  clr_cnt;
    logic              busy;         // table fill after reset
    logic [1:0]        cur_cnt;
    logic [1:0]        nxt_cnt;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            clr_cnt <= '0;
            busy    <= 1'b1;
        end else if (busy) begin
            clr_cnt <= clr_cnt + 1'b1;
            if (clr_cnt == IDX_W'(DEPTH - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    // saturating step toward the outcome
    assign cur_cnt = cnt_mem[upd.index];

    always_comb begin
        nxt_cnt = cur_cnt;
        if (upd.taken) begin
            if (cur_cnt != 2'b11) begin
                nxt_cnt = cur_cnt + 2'b01;
            end
        end else if (cur_cnt != 2'b00) begin
            nxt_cnt = cur_cnt - 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            cnt_mem[clr_cnt] <= 2'b01;      // weakly not taken
        end else if (upd.valid) begin
            cnt_mem[upd.index] <= nxt_cnt;
        end
    end

    // same-cycle write is not visible here
    assign taken = cnt_mem[rd_index][1];

endmodule

//--- verilog/branch_tracker.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module branch_tracker (
    input  logic                         clk,
    input  logic                         rstn,
    input  bp_fetch_pkg::pred_t          pred,
    input  bp_resolve_pkg::resolve_t     resolve,
    output bp_resolve_pkg::pht_upd_t     upd,
    output bp_resolve_pkg::mispredict_t  mispredict,
    output logic                         is_jump_ex
);

    localparam int DEPTH  = `BP_QUEUE_LEN;
    localparam int SLOT_W = $clog2(DEPTH);

    typedef struct packed {
        logic                  taken;
        logic [`BP_GH_WIDTH-1:0] index;
    } trk_entry_t;

    trk_entry_t       fifo_q [0:DEPTH-1];
    logic [SLOT_W:0]  wr_ptr;
    logic [SLOT_W:0]  rd_ptr;
    logic [SLOT_W:0]  occupancy;
    logic             empty;
    logic             push;
    logic             pop;
    logic             wrong;
    trk_entry_t       head;

    // extra pointer bit tells full from empty
    assign occupancy = wr_ptr - rd_ptr;
    assign empty     = (occupancy == '0);

    assign push  = pred.valid && pred.is_jump;
    assign pop   = resolve.valid && !empty;
    assign head  = fifo_q[rd_ptr[SLOT_W-1:0]];
    assign wrong = pop && (head.taken != resolve.taken);

    always_ff @(posedge clk) begin
        if (push && !wrong) begin
            fifo_q[wr_ptr[SLOT_W-1:0]] <= '{taken: pred.taken, index: pred.index};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (wrong) begin
            wr_ptr <= '0;                   // drop everything younger
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // train with the real outcome, right or wrong
    always_comb begin
        upd.valid        = pop;
        upd.index        = head.index;
        upd.taken        = resolve.taken;
        mispredict.valid = wrong;
        mispredict.index = head.index;
    end

    assign is_jump_ex = pop;

endmodule

//--- verilog/bp_gshare.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_gshare (
    input  logic                         clk,
    input  logic                         rstn,
    input  bp_fetch_pkg::fetch_req_t     fetch,
    input  bp_resolve_pkg::resolve_t     resolve,
    output bp_fetch_pkg::pred_t          pred,
    output bp_resolve_pkg::mispredict_t  mispredict,
    output logic [`BP_GH_WIDTH-1:0]      gh
);

    bp_fetch_pkg::pred_t          pred_req;
    logic [`BP_GH_WIDTH-1:0]      rd_index;
    logic                         pht_taken;
    bp_resolve_pkg::pht_upd_t     upd;
    logic                         is_jump_ex;
    logic                         update_en;

    fetch_capture fetch_capture_i (
        .clk      (clk),
        .rstn     (rstn),
        .fetch    (fetch),
        .gh       (gh),
        .flush    (mispredict.valid),
        .pred_req (pred_req),
        .index    (rd_index)
    );

    pht pht_i (
        .clk      (clk),
        .rstn     (rstn),
        .rd_index (rd_index),
        .taken    (pht_taken),
        .upd      (upd)
    );

    // counter msb is the guess
    always_comb begin
        pred       = pred_req;
        pred.taken = pht_taken;
    end

    // history moves on a predicted jump or any resolve
    assign update_en = (pred.valid && pred.is_jump) || resolve.valid;

    ghr ghr_i (
        .clk         (clk),
        .rstn        (rstn),
        .gh          (gh),
        .taken_pdc   (pred.taken),
        .mis_pdc     (mispredict.valid),
        .is_jump_pdc (pred.valid && pred.is_jump),
        .is_jump_ex  (is_jump_ex),
        .update_en   (update_en)
    );

    branch_tracker branch_tracker_i (
        .clk        (clk),
        .rstn       (rstn),
        .pred       (pred),
        .resolve    (resolve),
        .upd        (upd),
        .mispredict (mispredict),
        .is_jump_ex (is_jump_ex)
    );

endmodule

//--- verif/bp_gshare_props.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_gshare_props (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic [$clog2(`BP_QUEUE_LEN+1)-1:0]    level,
    input  logic                                  resolve_v,
    input  logic                                  mis_v
);

    // in-flight count bounded by the checkpoint depth
    a_level_max: assert property (@(posedge clk) disable iff (!rstn)
        level <= `BP_QUEUE_LEN)
        else $error("in-flight count above queue length");

    a_no_empty_resolve: assert property (@(posedge clk) disable iff (!rstn)
        resolve_v |-> level != '0)
        else $error("resolve with no jump in flight");

    // younger jumps squashed along with the wrong one
    a_mis_clears: assert property (@(posedge clk) disable iff (!rstn)
        mis_v |=> level == '0)
        else $error("in-flight count not cleared by mispredict");

    // queue is empty after a mispredict so no second pulse
    a_mis_single: assert property (@(posedge clk) disable iff (!rstn)
        mis_v |=> !mis_v)
        else $error("mispredict held for two cycles");

    a_reset_quiet: assert property (@(posedge clk)
        !rstn |-> !mis_v && !resolve_v)
        else $error("activity while in reset");

    a_reset_clear: assert property (@(posedge clk)
        !rstn |=> level == '0)
        else $error("in-flight count not cleared by reset");

endmodule

bind ghr bp_gshare_props ghr_props_i (
    .clk       (clk),
    .rstn      (rstn),
    .level     (pointer),
    .resolve_v (is_jump_ex),
    .mis_v     (mis_pdc)
);

bind branch_tracker bp_gshare_props trk_props_i (
    .clk       (clk),
    .rstn      (rstn),
    .level     (occupancy),
    .resolve_v (resolve.valid),
    .mis_v     (mispredict.valid)
);

//--- verif/bp_gshare_tb.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_gshare_tb;

    localparam int GH_W          = `BP_GH_WIDTH;
    localparam int RANDOM_CYCLES = 3000;
    localparam int FILL_TIMEOUT  = 5000;
    localparam logic [GH_W-1:0] DIR_INDEX     = 12'h5a5;
    localparam logic [7:0]      TRAIN_PATTERN = 8'b1111_0000;

    logic                         clk;
    logic                         rstn;
    bp_fetch_pkg::fetch_req_t     fetch;
    bp_resolve_pkg::resolve_t     resolve;
    bp_fetch_pkg::pred_t          pred;
    bp_resolve_pkg::mispredict_t  mispredict;
    logic [GH_W-1:0]              gh;

    logic [15:0]  lfsr_state;
    string        test_name;
    logic         model_on;
    logic         run_ended;

    // reference model state
    logic [1:0]              m_cnt [0:(1 << GH_W)-1];
    logic [GH_W-1:0]         m_gh;
    logic                    m_reg_valid;
    logic                    m_reg_jump;
    logic [`BP_PC_WIDTH-1:0] m_reg_pc;
    logic                    q_taken [$];   // oldest in flight first
    logic [GH_W-1:0]         q_index [$];
    logic [GH_W-1:0]         q_gh [$];      // history seen at prediction
    logic [`BP_PC_WIDTH-1:0] q_pc [$];

    bp_gshare dut_i (
        .clk        (clk),
        .rstn       (rstn),
        .fetch      (fetch),
        .resolve    (resolve),
        .pred       (pred),
        .mispredict (mispredict),
        .gh         (gh)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic bp_fetch_pkg::pred_t expect_pred();
        bp_fetch_pkg::pred_t p;
        p.valid   = m_reg_valid;
        p.is_jump = m_reg_jump;
        p.index   = m_reg_pc[`BP_PC_LSB +: GH_W] ^ m_gh;
        p.taken   = m_cnt[p.index][1];       // counter msb
        return p;
    endfunction

    function automatic bp_resolve_pkg::mispredict_t expect_mispredict();
        bp_resolve_pkg::mispredict_t m;
        m = '0;
        if (resolve.valid && q_taken.size() != 0) begin
            m.valid = (q_taken[0] != resolve.taken);
            m.index = q_index[0];
        end
        return m;
    endfunction

    task automatic advance_model();
        bp_fetch_pkg::pred_t          p;
        bp_resolve_pkg::mispredict_t  m;
        logic [1:0]                   c;
        p = expect_pred();
        m = expect_mispredict();
        if (resolve.valid && q_taken.size() != 0) begin
            c = m_cnt[q_index[0]];
            if (resolve.taken && c != 2'b11) begin
                c = c + 2'b01;
            end else if (!resolve.taken && c != 2'b00) begin
                c = c - 2'b01;
            end
            m_cnt[q_index[0]] = c;
            if (m.valid) begin
                m_gh = {q_gh[0][GH_W-2:0], resolve.taken};
            end
            void'(q_taken.pop_front());
            void'(q_index.pop_front());
            void'(q_gh.pop_front());
            void'(q_pc.pop_front());
        end
        if (m.valid) begin
            q_taken.delete();                // younger jumps squashed
            q_index.delete();
            q_gh.delete();
            q_pc.delete();
        end else if (p.valid && p.is_jump) begin
            q_taken.push_back(p.taken);
            q_index.push_back(p.index);
            q_gh.push_back(m_gh);
            q_pc.push_back(m_reg_pc);
            m_gh = {m_gh[GH_W-2:0], p.taken};
        end
        m_reg_valid = fetch.valid && !m.valid;
        m_reg_jump  = fetch.is_jump;
        m_reg_pc    = fetch.pc;
    endtask

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error [%s] %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("Test FAILED");
            run_ended = 1'b1;
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic apply(logic fv, logic fj, logic [31:0] pc, logic rv, logic rt);
        fetch.valid   = fv;
        fetch.is_jump = fj;
        fetch.pc      = pc;
        resolve.valid = rv && (q_taken.size() != 0);   // never on an empty tracker
        resolve.taken = rt;
    endtask

    // jump at a fixed index, then its resolve while a plain fetch reads the same index
    task automatic train_step(logic outcome);
        logic [GH_W-1:0] gh_at_resolve;
        tick();
        apply(1'b1, 1'b1, 32'(DIR_INDEX ^ m_gh) << `BP_PC_LSB, 1'b0, 1'b0);
        tick();
        gh_at_resolve = {m_gh[GH_W-2:0], m_cnt[DIR_INDEX][1]};   // after the jump's shift
        apply(1'b1, 1'b0, 32'(DIR_INDEX ^ gh_at_resolve) << `BP_PC_LSB, 1'b0, 1'b0);
        tick();
        apply(1'b0, 1'b0, '0, 1'b1, outcome);
        tick();
        apply(1'b0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic random_cycle(int cyc);
        logic        fv;
        logic        fj;
        logic        rt;
        logic [31:0] pc;
        int          in_flight;
        int          rate;
        in_flight = q_taken.size() + ((m_reg_valid && m_reg_jump) ? 1 : 0);
        fv   = (rand_bits(2) != 0);
        fj   = rand_bits(1) && (in_flight < `BP_QUEUE_LEN);
        pc   = 32'h0000_1000 + (rand_bits(5) << 2);
        rate = (cyc % 512 < 128) ? 0 : ((cyc % 512 < 256) ? 1 : 3);  // stalls fill the queue
        rt   = (q_pc.size() != 0) ? (q_pc[0][5] ^ (rand_bits(3) == 0)) : 1'b0;
        apply(fv, fj, pc, rand_bits(2) < rate, rt);
    endtask

    always @(negedge clk) begin
        bp_fetch_pkg::pred_t          exp_p;
        bp_resolve_pkg::mispredict_t  exp_m;
        if (model_on) begin
            exp_p = expect_pred();
            exp_m = expect_mispredict();
            check_value("pred.valid", exp_p.valid, pred.valid);
            if (exp_p.valid) begin
                check_value("pred", exp_p, pred);
            end
            check_value("mispredict.valid", exp_m.valid, mispredict.valid);
            if (exp_m.valid) begin
                check_value("mispredict.index", exp_m.index, mispredict.index);
            end
            check_value("gh", m_gh, gh);
            advance_model();
        end
    end

    initial begin
        int waited;
        fetch       = '0;
        resolve     = '0;
        rstn        = 1'b0;
        model_on    = 1'b0;
        run_ended   = 1'b0;
        lfsr_state  = 16'd31825;
        test_name   = "reset";
        m_gh        = '0;
        m_reg_valid = 1'b0;
        m_reg_jump  = 1'b0;
        m_reg_pc    = '0;
        for (int i = 0; i < (1 << GH_W); i++) begin
            m_cnt[i] = 2'b01;                // weakly not taken
        end
        repeat (2) @(posedge clk);
        #1;
        rstn   = 1'b1;
        waited = 0;
        while (dut_i.pht_i.busy !== 1'b0) begin
            tick();
            waited++;
            if (waited > FILL_TIMEOUT) begin
                $display("counter table fill did not end within %0d cycles", FILL_TIMEOUT);
                $display("Test FAILED");
                run_ended = 1'b1;
                $fatal(1, "fill timeout");
            end
        end
        model_on = 1'b1;
        repeat (4) begin
            tick();
            apply(1'b0, 1'b0, '0, 1'b0, 1'b0);
        end
        test_name = "train";
        for (int i = 7; i >= 0; i--) begin
            train_step(TRAIN_PATTERN[i]);
        end
        test_name = "random";
        for (int cyc = 0; cyc < RANDOM_CYCLES; cyc++) begin
            tick();
            random_cycle(cyc);
        end
        tick();
        apply(1'b0, 1'b0, '0, 1'b0, 1'b0);
        tick();
        run_ended = 1'b1;
        $display("Test OK");
        $finish;
    end

    // run stopped by something other than the checks above
    final begin
        if (!run_ended) begin
            $display("Test FAILED");
        end
    end

endmodule

//--- bp_gshare.f
+incdir+verilog
verilog/bp_fetch_pkg.sv
verilog/bp_resolve_pkg.sv
verilog/fetch_capture.sv
verilog/ghr.sv
verilog/pht.sv
verilog/branch_tracker.sv
verilog/bp_gshare.sv
verif/bp_gshare_props.sv
verif/bp_gshare_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module bp_gshare_tb -f bp_gshare.f -o bp_gshare_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/bp_gshare_sim > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "Test FAILED" "$SIM_LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0
